// ==== hdl/llm_int_pkg.sv ====
package llm_int_pkg;

  // vector length and the square weight matrix
  localparam int dim = 4;
  localparam int n_weights = dim * dim;
  localparam int addr_w = $clog2(n_weights);

  // element precisions of the two paths
  localparam int wide_w = 32;
  localparam int narrow_w = 8;

  // outlier split: at most high_slots elements per vector take the wide path
  localparam int high_slots = 2;
  localparam int threshold = 100;

  // saturation range of the quantized path
  localparam int narrow_max = 2 ** (narrow_w - 1) - 1;
  localparam int narrow_min = -(2 ** (narrow_w - 1));

  // full-precision element, also used for all sums and outputs
  typedef logic signed [wide_w-1:0] wide_t;

  // quantized element
  typedef logic signed [narrow_w-1:0] narrow_t;

endpackage

// ==== hdl/weight_bank.sv ====
`timescale 1ns/100ps

module weight_bank (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            wr_en,
  input  logic                            wr_narrow,
  input  logic [llm_int_pkg::addr_w-1:0]  wr_addr,
  input  llm_int_pkg::wide_t              wr_data,
  output llm_int_pkg::wide_t              weights [llm_int_pkg::n_weights],
  output llm_int_pkg::narrow_t            q_weights [llm_int_pkg::n_weights]
);

  // one-hot decode of the write address
  logic [llm_int_pkg::n_weights-1:0] sel;

  always_comb begin
    sel = '0;
    sel[wr_addr] = wr_en;
  end

  // full-precision matrix, row r column c at address r*dim+c
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < llm_int_pkg::n_weights; i++) begin
        weights[i] <= '0;
      end
    end else begin
      for (int i = 0; i < llm_int_pkg::n_weights; i++) begin
        if (sel[i] && !wr_narrow) begin
          weights[i] <= wr_data;
        end
      end
    end
  end

  // quantized matrix, only the low byte of the write data is kept
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < llm_int_pkg::n_weights; i++) begin
        q_weights[i] <= '0;
      end
    end else begin
      for (int i = 0; i < llm_int_pkg::n_weights; i++) begin
        if (sel[i] && wr_narrow) begin
          q_weights[i] <= llm_int_pkg::narrow_t'(wr_data);
        end
      end
    end
  end

endmodule

// ==== hdl/scatter_threshold.sv ====
`timescale 1ns/100ps

module scatter_threshold (
  input  logic                  clk,
  input  logic                  arst_n,
  input  llm_int_pkg::wide_t    in_data [llm_int_pkg::dim],
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic                  out_ready,
  output logic                  out_valid,
  output llm_int_pkg::wide_t    high_data [llm_int_pkg::dim],
  output llm_int_pkg::narrow_t  low_data [llm_int_pkg::dim]
);

  logic                 is_big [llm_int_pkg::dim];
  llm_int_pkg::wide_t   high_next [llm_int_pkg::dim];
  llm_int_pkg::narrow_t low_next [llm_int_pkg::dim];

  // magnitude test as two compares, so the most negative input needs no abs
  always_comb begin
    for (int j = 0; j < llm_int_pkg::dim; j++) begin
      is_big[j] = (in_data[j] >= llm_int_pkg::threshold) ||
                  (in_data[j] <= -llm_int_pkg::threshold);
    end
  end

  // classify in index order; once the slots are used up, outliers fall
  // through to the saturating path
  always_comb begin
    int taken;
    taken = 0;
    for (int j = 0; j < llm_int_pkg::dim; j++) begin
      if (is_big[j] && (taken < llm_int_pkg::high_slots)) begin
        high_next[j] = in_data[j];
        low_next[j] = '0;
        taken = taken + 1;
      end else begin
        high_next[j] = '0;
        if (in_data[j] > llm_int_pkg::narrow_max) begin
          low_next[j] = llm_int_pkg::narrow_t'(llm_int_pkg::narrow_max);
        end else if (in_data[j] < llm_int_pkg::narrow_min) begin
          low_next[j] = llm_int_pkg::narrow_t'(llm_int_pkg::narrow_min);
        end else begin
          low_next[j] = llm_int_pkg::narrow_t'(in_data[j]);
        end
      end
    end
  end

  // single-entry stage: free when empty or when the item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      high_data <= high_next;
      low_data <= low_next;
    end
  end

endmodule

// ==== hdl/mixed_linear.sv ====
`timescale 1ns/100ps

module mixed_linear #(
  parameter type elem_t = llm_int_pkg::wide_t
) (
  input  logic                clk,
  input  logic                arst_n,
  input  elem_t               in_data [llm_int_pkg::dim],
  input  elem_t               weights [llm_int_pkg::n_weights],
  input  logic                in_valid,
  output logic                in_ready,
  input  logic                out_ready,
  output logic                out_valid,
  output llm_int_pkg::wide_t  out_data [llm_int_pkg::dim]
);

  // stage one: all products of the matrix
  llm_int_pkg::wide_t prod_q [llm_int_pkg::n_weights];
  logic               prod_valid;

  // stage two: row sums
  llm_int_pkg::wide_t row_sum [llm_int_pkg::dim];
  logic               sum_ready;

  assign sum_ready = !out_valid || out_ready;
  assign in_ready = !prod_valid || sum_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_valid <= 1'b0;
    end else if (in_ready) begin
      prod_valid <= in_valid;
    end
  end

  // operands are sign-extended to the wide type first, products wrap at 32 bits
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      for (int r = 0; r < llm_int_pkg::dim; r++) begin
        for (int c = 0; c < llm_int_pkg::dim; c++) begin
          prod_q[r*llm_int_pkg::dim+c] <=
            llm_int_pkg::wide_t'(weights[r*llm_int_pkg::dim+c]) *
            llm_int_pkg::wide_t'(in_data[c]);
        end
      end
    end
  end

  always_comb begin
    for (int r = 0; r < llm_int_pkg::dim; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < llm_int_pkg::dim; c++) begin
        row_sum[r] = row_sum[r] + prod_q[r*llm_int_pkg::dim+c];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (sum_ready) begin
      out_valid <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (prod_valid && sum_ready) begin
      out_data <= row_sum;
    end
  end

endmodule

// ==== hdl/gather.sv ====
`timescale 1ns/100ps

module gather (
  input  logic                clk,
  input  logic                arst_n,
  input  llm_int_pkg::wide_t  high_data [llm_int_pkg::dim],
  input  llm_int_pkg::wide_t  low_data [llm_int_pkg::dim],
  input  logic                high_valid,
  input  logic                low_valid,
  output logic                in_ready,
  output llm_int_pkg::wide_t  out_data [llm_int_pkg::dim],
  output logic                out_valid,
  input  logic                out_ready
);

  // both partial results must be present before the join
  logic both_valid;

  assign both_valid = high_valid && low_valid;
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= both_valid;
    end
  end

  // element-wise sum, held while the consumer stalls
  always_ff @(posedge clk) begin
    if (both_valid && in_ready) begin
      for (int i = 0; i < llm_int_pkg::dim; i++) begin
        out_data[i] <= high_data[i] + low_data[i];
      end
    end
  end

endmodule

// ==== hdl/llm_int_top.sv ====
`timescale 1ns/100ps

module llm_int_top (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            wr_en,
  input  logic                            wr_narrow,
  input  logic [llm_int_pkg::addr_w-1:0]  wr_addr,
  input  llm_int_pkg::wide_t              wr_data,
  input  llm_int_pkg::wide_t              data_in [llm_int_pkg::dim],
  input  logic                            data_in_valid,
  output logic                            data_in_ready,
  output llm_int_pkg::wide_t              data_out [llm_int_pkg::dim],
  output logic                            data_out_valid,
  input  logic                            data_out_ready
);

  // weight bank outputs
  llm_int_pkg::wide_t   weights [llm_int_pkg::n_weights];
  llm_int_pkg::narrow_t q_weights [llm_int_pkg::n_weights];

  // scatter to linear paths
  llm_int_pkg::wide_t   split_high [llm_int_pkg::dim];
  llm_int_pkg::narrow_t split_low [llm_int_pkg::dim];
  logic                 split_valid;
  logic                 split_ready;
  logic                 high_in_ready;
  logic                 low_in_ready;

  // linear paths to gather
  llm_int_pkg::wide_t   high_sum [llm_int_pkg::dim];
  llm_int_pkg::wide_t   low_sum [llm_int_pkg::dim];
  logic                 high_sum_valid;
  logic                 low_sum_valid;
  logic                 gather_ready;

  weight_bank i_weight_bank (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_en     (wr_en),
    .wr_narrow (wr_narrow),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .weights   (weights),
    .q_weights (q_weights)
  );

  scatter_threshold i_scatter (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (data_in),
    .in_valid  (data_in_valid),
    .in_ready  (data_in_ready),
    .out_ready (split_ready),
    .out_valid (split_valid),
    .high_data (split_high),
    .low_data  (split_low)
  );

  // the two paths run in lockstep, so scatter waits for both
  assign split_ready = high_in_ready & low_in_ready;

  mixed_linear #(
    .elem_t (llm_int_pkg::wide_t)
  ) i_linear_high (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (split_high),
    .weights   (weights),
    .in_valid  (split_valid),
    .in_ready  (high_in_ready),
    .out_ready (gather_ready),
    .out_valid (high_sum_valid),
    .out_data  (high_sum)
  );

  mixed_linear #(
    .elem_t (llm_int_pkg::narrow_t)
  ) i_linear_low (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_data   (split_low),
    .weights   (q_weights),
    .in_valid  (split_valid),
    .in_ready  (low_in_ready),
    .out_ready (gather_ready),
    .out_valid (low_sum_valid),
    .out_data  (low_sum)
  );

  gather i_gather (
    .clk        (clk),
    .arst_n     (arst_n),
    .high_data  (high_sum),
    .low_data   (low_sum),
    .high_valid (high_sum_valid),
    .low_valid  (low_sum_valid),
    .in_ready   (gather_ready),
    .out_data   (data_out),
    .out_valid  (data_out_valid),
    .out_ready  (data_out_ready)
  );

endmodule

// ==== test/llm_int_props.sv ====
`timescale 1ns/100ps

module llm_int_props (
  input logic               clk,
  input logic               arst_n,
  input logic               data_in_valid,
  input logic               data_in_ready,
  input llm_int_pkg::wide_t data_out [llm_int_pkg::dim],
  input logic               data_out_valid,
  input logic               data_out_ready
);

  localparam int w = llm_int_pkg::wide_w;

  logic [llm_int_pkg::dim*w-1:0] out_flat;

  always_comb begin
    for (int i = 0; i < llm_int_pkg::dim; i++) begin
      out_flat[i*w +: w] = data_out[i];
    end
  end

  // nothing leaves and the input side is open while reset is held
  reset_idle: assert property (@(posedge clk) !arst_n |-> !data_out_valid && data_in_ready)
    else $error("data_out_valid or data_in_ready wrong during reset");

  out_stable: assert property (@(posedge clk) disable iff (!arst_n)
    data_out_valid && !data_out_ready |=> $stable(out_flat))
    else $error("data_out changed while stalled");

  out_valid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    data_out_valid && !data_out_ready |=> data_out_valid)
    else $error("data_out_valid dropped before the transfer");

  in_valid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    data_in_valid && !data_in_ready |=> data_in_valid)
    else $error("data_in_valid dropped before the transfer");

endmodule

bind llm_int_top llm_int_props i_props (
  .clk            (clk),
  .arst_n         (arst_n),
  .data_in_valid  (data_in_valid),
  .data_in_ready  (data_in_ready),
  .data_out       (data_out),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready)
);

// ==== test/llm_int_tb.sv ====
`timescale 1ns/100ps

module llm_int_tb;

  localparam int n_rows = 15;
  localparam int n_random = 200;
  localparam int n_burst = 6;
  // one more vector for the latency probe
  localparam int n_total = n_rows + n_random + n_burst + 1;
  localparam int cycle_limit = 8 * n_total + 200;
  localparam int vec_w = llm_int_pkg::dim * llm_int_pkg::wide_w;

  logic                           clk;
  logic                           arst_n;
  logic                           wr_en;
  logic                           wr_narrow;
  logic [llm_int_pkg::addr_w-1:0] wr_addr;
  llm_int_pkg::wide_t             wr_data;
  llm_int_pkg::wide_t             data_in [llm_int_pkg::dim];
  logic                           data_in_valid;
  logic                           data_in_ready;
  llm_int_pkg::wide_t             data_out [llm_int_pkg::dim];
  logic                           data_out_valid;
  logic                           data_out_ready;

  // host-side copies of both weight matrices
  int               w_model [llm_int_pkg::n_weights];
  int               q_model [llm_int_pkg::n_weights];
  logic [vec_w-1:0] exp_q [$];
  logic [7:0]       rdy_pat;
  int               cyc = 0;
  int               value_errors;
  int               other_errors;
  logic             burst_on;
  int               burst_outs;
  int               last_out_cyc;

  // wset picks the weight set and rdy the data_out_ready bit pattern
  typedef struct packed {
    logic [3:0]         wset;
    logic [7:0]         rdy;
    logic signed [31:0] e0;
    logic signed [31:0] e1;
    logic signed [31:0] e2;
    logic signed [31:0] e3;
  } row_t;

  row_t stim [n_rows] = '{
    '{4'd0, 8'hff, 32'sd5, -32'sd7, 32'sd300, -32'sd1000},
    '{4'd1, 8'hff, 32'sd1, 32'sd2, 32'sd3, 32'sd4},
    '{4'd1, 8'hff, -32'sd50, 32'sd99, -32'sd99, 32'sd0},
    '{4'd1, 8'h96, 32'sd17, -32'sd128, 32'sd127, -32'sd3},
    '{4'd2, 8'hff, 32'sd1, 32'sd2, 32'sd3, 32'sd4},
    '{4'd2, 8'hb7, -32'sd60, 32'sd45, 32'sd99, -32'sd99},
    '{4'd3, 8'hff, 32'sd99, -32'sd99, 32'sd10, -32'sd20},
    '{4'd3, 8'hff, 32'sd100, 32'sd5, -32'sd6, 32'sd7},
    '{4'd3, 8'ha5, -32'sd3, -32'sd100, 32'sd99, 32'sd0},
    '{4'd3, 8'ha5, 32'sd100, -32'sd100, 32'sd99, -32'sd99},
    '{4'd3, 8'h5a, 32'sd12, 32'sd70000, -32'sd99, 32'sh8000_0000},
    '{4'd3, 8'hff, 32'sd150, -32'sd200, 32'sd300, 32'sd4},
    '{4'd3, 8'h6d, -32'sd1000, 32'sd5, -32'sd101, -32'sd100},
    '{4'd3, 8'hff, 32'sd100, 32'sd100, 32'sd1000, -32'sd1000},
    '{4'd3, 8'h3c, -32'sd500, 32'sd250, -32'sd130, 32'sd128}
  };

  llm_int_top i_dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .wr_en          (wr_en),
    .wr_narrow      (wr_narrow),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // split the vector by magnitude, then both matrix products, wrapped to 32 bits
  function automatic logic [vec_w-1:0] expected_vector(
    input llm_int_pkg::wide_t v [llm_int_pkg::dim]
  );
    longint           h [llm_int_pkg::dim];
    longint           l [llm_int_pkg::dim];
    longint           x;
    longint           mag;
    longint           acc;
    int               slots;
    logic [vec_w-1:0] res;
    slots = 0;
    for (int j = 0; j < llm_int_pkg::dim; j++) begin
      x = v[j];
      mag = (x < 0) ? -x : x;
      if (mag >= llm_int_pkg::threshold && slots < llm_int_pkg::high_slots) begin
        h[j] = x;
        l[j] = 0;
        slots++;
      end else begin
        h[j] = 0;
        l[j] = (x > 127) ? 127 : ((x < -128) ? -128 : x);
      end
    end
    for (int i = 0; i < llm_int_pkg::dim; i++) begin
      acc = 0;
      for (int j = 0; j < llm_int_pkg::dim; j++) begin
        acc += longint'(w_model[i*4+j]) * h[j] + longint'(q_model[i*4+j]) * l[j];
      end
      res[32*i +: 32] = acc[31:0];
    end
    return res;
  endfunction

  function automatic llm_int_pkg::wide_t random_element();
    int unsigned r;
    r = $urandom;
    case (r % 4)
      0: return $urandom;
      1: return int'($urandom % 401) - 200;
      default: return int'($urandom % 241) - 120;
    endcase
  endfunction

  // full matrix first, then the quantized one with junk in the upper bits
  task automatic load_weights(input int wset);
    logic [31:0] d;
    int          a;
    int          r;
    int          c;
    logic        narrow;
    for (int n = 0; n < 2 * llm_int_pkg::n_weights; n++) begin
      a = n % llm_int_pkg::n_weights;
      r = a / 4;
      c = a % 4;
      narrow = (n >= llm_int_pkg::n_weights);
      case (wset)
        1: d = (r == c) ? 32'd1 : 32'd0;
        2: d = (r == c) ? (narrow ? 32'd2 : 32'd1) : 32'd0;
        3: d = narrow ? 32'(5 - a) : 32'(3 * a - 20);
        default: d = $urandom;
      endcase
      if (narrow) begin
        d[31:8] = d[31:8] ^ 24'ha5a5a5;
        q_model[a] = $signed(d[7:0]);
      end else begin
        w_model[a] = $signed(d);
      end
      @(negedge clk);
      wr_en = 1'b1;
      wr_narrow = narrow;
      wr_addr = a[llm_int_pkg::addr_w-1:0];
      wr_data = d;
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  // returns at the rising edge where the vector is accepted
  task automatic send_vector(
    input llm_int_pkg::wide_t v [llm_int_pkg::dim],
    input logic [7:0]         rdy
  );
    exp_q.push_back(expected_vector(v));
    @(negedge clk);
    data_in = v;
    data_in_valid = 1'b1;
    rdy_pat = rdy;
    @(posedge clk);
    while (!data_in_ready) begin
      @(posedge clk);
    end
  endtask

  task automatic drain_pipeline;
    @(negedge clk);
    data_in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  // ready pattern walks bit by bit, picked at the rising edge
  initial begin : ready_driver
    int   idx;
    logic nxt;
    idx = 0;
    forever begin
      @(posedge clk);
      nxt = rdy_pat[idx];
      idx = (idx + 1) % 8;
      @(negedge clk);
      data_out_ready = nxt;
    end
  end

  always @(posedge clk) begin : monitor
    logic [vec_w-1:0] exp_v;
    if (arst_n && data_out_valid && data_out_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("output vector at %0t arrived with no vector outstanding", $time);
        other_errors++;
      end
      if (exp_q.size() != 0) begin
        exp_v = exp_q.pop_front();
        for (int i = 0; i < llm_int_pkg::dim; i++) begin
          assert (data_out[i] === exp_v[32*i +: 32]) else begin
            $display("** Error at %0t: data_out[%0d] expected %0d, got %0d",
                     $time, i, $signed(exp_v[32*i +: 32]), data_out[i]);
            value_errors++;
          end
        end
      end
      if (burst_on) begin
        if (burst_outs > 0) begin
          assert (cyc == last_out_cyc + 1) else begin
            $display("burst output at %0t did not follow the previous one directly", $time);
            other_errors++;
          end
        end
        burst_outs++;
        last_out_cyc = cyc;
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles with vectors still pending", cyc);
      $display("errors: %0d value, %0d other", value_errors, other_errors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    llm_int_pkg::wide_t vec [llm_int_pkg::dim];
    int                 cur_wset;
    int                 lat;
    void'($urandom(32'h14fb_0733));
    arst_n = 1'b0;
    wr_en = 1'b0;
    wr_narrow = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    data_in = '{default: '0};
    data_in_valid = 1'b0;
    data_out_ready = 1'b0;
    rdy_pat = 8'hff;
    value_errors = 0;
    other_errors = 0;
    burst_on = 1'b0;
    burst_outs = 0;
    last_out_cyc = 0;
    w_model = '{default: 0};
    q_model = '{default: 0};
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    assert (data_out_valid === 1'b0) else begin
      $display("** Error at %0t: data_out_valid expected 0, got %b", $time, data_out_valid);
      value_errors++;
    end
    assert (data_in_ready === 1'b1) else begin
      $display("** Error at %0t: data_in_ready expected 1, got %b", $time, data_in_ready);
      value_errors++;
    end

    cur_wset = 0;
    for (int k = 0; k < n_rows; k++) begin
      if (stim[k].wset != cur_wset) begin
        drain_pipeline();
        load_weights(stim[k].wset);
        cur_wset = stim[k].wset;
      end
      vec[0] = stim[k].e0;
      vec[1] = stim[k].e1;
      vec[2] = stim[k].e2;
      vec[3] = stim[k].e3;
      send_vector(vec, stim[k].rdy);
    end
    drain_pipeline();

    // lone vector with the consumer always ready
    rdy_pat = 8'hff;
    repeat (2) @(negedge clk);
    vec = '{32'sd11, -32'sd150, 32'sd40, 32'sd101};
    send_vector(vec, 8'hff);
    lat = 0;
    do begin
      @(negedge clk);
      data_in_valid = 1'b0;
      lat++;
    end while (!data_out_valid && lat < 12);
    assert (lat == 4) else begin
      $display("data_out_valid rose %0d cycles after acceptance instead of 4", lat);
      other_errors++;
    end
    drain_pipeline();

    burst_on = 1'b1;
    for (int k = 0; k < n_burst; k++) begin
      for (int j = 0; j < llm_int_pkg::dim; j++) begin
        vec[j] = k * 37 + j * 91 - 150;
      end
      send_vector(vec, 8'hff);
    end
    drain_pipeline();
    burst_on = 1'b0;
    assert (burst_outs == n_burst) else begin
      $display("burst gave %0d output vectors instead of %0d", burst_outs, n_burst);
      other_errors++;
    end

    // random weights, data and back-pressure
    load_weights(4);
    for (int k = 0; k < n_random; k++) begin
      for (int j = 0; j < llm_int_pkg::dim; j++) begin
        vec[j] = random_element();
      end
      send_vector(vec, 8'($urandom) | 8'h01);
    end
    drain_pipeline();
    repeat (2) @(negedge clk);

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/llm_int_pkg.sv
hdl/weight_bank.sv
hdl/scatter_threshold.sv
hdl/mixed_linear.sv
hdl/gather.sv
hdl/llm_int_top.sv
test/llm_int_props.sv
test/llm_int_tb.sv

// ==== Bender.yml ====
package:
  name: llm_int

sources:
  - hdl/llm_int_pkg.sv
  - hdl/weight_bank.sv
  - hdl/scatter_threshold.sv
  - hdl/mixed_linear.sv
  - hdl/gather.sv
  - hdl/llm_int_top.sv
  - target: test
    files:
      - test/llm_int_props.sv
      - test/llm_int_tb.sv
